// ==== hw/cpu_timing_pkg.sv ====
package cpu_timing_pkg;

    // One instruction frame in 100 MHz clocks
    localparam int FRAME_LEN = 102;
    localparam int CNT_W     = $clog2(FRAME_LEN);

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(FRAME_LEN - 1);

    // Fetch is high at the start of the frame, long enough for the memory read
    localparam logic [CNT_W-1:0] FETCH_END = 7'd49;

    // ALU starts a few clocks after fetch so the instruction register is settled
    localparam logic [CNT_W-1:0] ALU_START = 7'd6;
    localparam logic [CNT_W-1:0] ALU_END   = 7'd69;

    // RAM and write-back both run to the end of the frame
    localparam logic [CNT_W-1:0] RAM_START = 7'd80;
    localparam logic [CNT_W-1:0] REG_START = 7'd90;

endpackage

// ==== hw/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    localparam int DATA_W  = 8;
    localparam int NREGS   = 8;
    localparam int REG_AW  = $clog2(NREGS);
    localparam int PROG_AW = 8;
    localparam int DATA_AW = 8;
    localparam int INSTR_W = 16;

    localparam int PROG_DEPTH = 2 ** PROG_AW;
    localparam int DATA_DEPTH = 2 ** DATA_AW;

    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        LDI  = 4'h5,
        LD   = 4'h6,
        ST   = 4'h7,
        OUT  = 4'h8,
        HALT = 4'h9
    } opcode_e;

    // Register to register form used by the ALU operations
    typedef struct packed {
        opcode_e           op;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [2:0]        spare;
    } r_form_t;

    // Immediate form, rd is the source register for ST and OUT
    typedef struct packed {
        opcode_e           op;
        logic [REG_AW-1:0] rd;
        logic              spare;
        logic [DATA_W-1:0] imm;
    } m_form_t;

    typedef union packed {
        r_form_t r_form;
        m_form_t m_form;
    } instr_t;

endpackage

// ==== hw/cpu_ifs.sv ====
`timescale 1ns/1ps

// Phase levels shared by every stage of the core
interface phase_if;
    logic fetch_ph;
    logic alu_ph;
    logic ram_ph;
    logic reg_ph;

    modport gen (
        output fetch_ph,
        output alu_ph,
        output ram_ph,
        output reg_ph
    );

    modport user (
        input fetch_ph,
        input alu_ph,
        input ram_ph,
        input reg_ph
    );
endinterface

// Data memory port between the execute unit and the RAM
interface mem_if import cpu_isa_pkg::*; ();
    logic               we;
    logic [DATA_AW-1:0] addr;
    logic [DATA_W-1:0]  wdata;
    logic [DATA_W-1:0]  rdata;

    modport master (
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );
endinterface

// ==== hw/phase_gen.sv ====
`timescale 1ns/1ps

module phase_gen import cpu_timing_pkg::*; (
    input  logic clk_100M,
    input  logic rst_n,
    input  logic run,
    input  logic halted,
    phase_if.gen ph
);

    logic [CNT_W-1:0] cnt;
    logic             adv;
    logic             fetch_nxt;
    logic             alu_nxt;
    logic             ram_nxt;
    logic             reg_nxt;

    // Everything holds while the core is stopped or has halted
    assign adv = run && !halted;

    always_ff @(posedge clk_100M or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (adv) begin
            if (cnt == LAST_CNT) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Phase windows decoded from the current count
    always_comb begin
        fetch_nxt = (cnt <= FETCH_END);
        alu_nxt   = (cnt >= ALU_START) && (cnt <= ALU_END);
        ram_nxt   = (cnt >= RAM_START);
        reg_nxt   = (cnt >= REG_START);
    end

    // Levels are registered so they trail the counter by one clock
    always_ff @(posedge clk_100M or negedge rst_n) begin
        if (!rst_n) begin
            ph.fetch_ph <= 1'b0;
            ph.alu_ph   <= 1'b0;
            ph.ram_ph   <= 1'b0;
            ph.reg_ph   <= 1'b0;
        end else if (adv) begin
            ph.fetch_ph <= fetch_nxt;
            ph.alu_ph   <= alu_nxt;
            ph.ram_ph   <= ram_nxt;
            ph.reg_ph   <= reg_nxt;
        end
    end

endmodule

// ==== hw/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch import cpu_isa_pkg::*; (
    input  logic               clk_100M,
    input  logic               rst_n,
    input  logic               prog_we,
    input  logic [PROG_AW-1:0] prog_addr,
    input  instr_t             prog_data,
    phase_if.user              ph,
    output instr_t             instr
);

    instr_t             prog_mem [PROG_DEPTH];
    logic [PROG_AW-1:0] pc;
    logic               fetch_d;
    logic               fetch_rise;

    assign fetch_rise = ph.fetch_ph && !fetch_d;

    // Load port, only written while the core is stopped
    always_ff @(posedge clk_100M) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk_100M or negedge rst_n) begin
        if (!rst_n) begin
            fetch_d <= 1'b0;
        end else begin
            fetch_d <= ph.fetch_ph;
        end
    end

    // One instruction per frame, pc simply wraps at the end of memory
    always_ff @(posedge clk_100M or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            instr <= '0;
        end else if (fetch_rise) begin
            instr <= prog_mem[pc];
            pc    <= pc + 1'b1;
        end
    end

endmodule

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps

module data_ram import cpu_isa_pkg::*; (
    input  logic   clk_100M,
    input  logic   rst_n,
    phase_if.user  ph,
    mem_if.slave   mem
);

    logic [DATA_W-1:0] ram [DATA_DEPTH];
    logic              ram_d;
    logic              ram_rise;

    assign ram_rise = ph.ram_ph && !ram_d;

    always_ff @(posedge clk_100M) begin
        if (ram_rise && mem.we) begin
            ram[mem.addr] <= mem.wdata;
        end
    end

    // Read data is captured once per frame and held until the next RAM phase
    always_ff @(posedge clk_100M or negedge rst_n) begin
        if (!rst_n) begin
            ram_d     <= 1'b0;
            mem.rdata <= '0;
        end else begin
            ram_d <= ph.ram_ph;
            if (ram_rise && !mem.we) begin
                mem.rdata <= ram[mem.addr];
            end
        end
    end

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import cpu_isa_pkg::*; (
    input  logic              clk_100M,
    input  logic              rst_n,
    phase_if.user             ph,
    input  instr_t            instr,
    mem_if.master             mem,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    output logic              halted
);

    logic [DATA_W-1:0] regs [NREGS];
    logic [DATA_W-1:0] src_a;
    logic [DATA_W-1:0] src_b;
    logic [DATA_W-1:0] src_d;
    logic [DATA_W-1:0] alu_out;
    logic [DATA_W-1:0] result;
    opcode_e           op;
    logic              alu_d;
    logic              reg_d;
    logic              alu_rise;
    logic              reg_rise;

    assign op = instr.r_form.op;

    // ALU operands come from the register form, ST and OUT read rd of the immediate form
    assign src_a = regs[instr.r_form.rs1];
    assign src_b = regs[instr.r_form.rs2];
    assign src_d = regs[instr.m_form.rd];

    assign alu_rise = ph.alu_ph && !alu_d;
    assign reg_rise = ph.reg_ph && !reg_d;

    always_comb begin
        alu_out = '0;
        case (op)
            ADD:     alu_out = src_a + src_b;
            SUB:     alu_out = src_a - src_b;
            AND:     alu_out = src_a & src_b;
            OR:      alu_out = src_a | src_b;
            XOR:     alu_out = src_a ^ src_b;
            LDI:     alu_out = instr.m_form.imm;
            OUT:     alu_out = src_d;
            default: alu_out = '0;
        endcase
    end

    // Result and memory request are set up once per frame in the ALU phase
    always_ff @(posedge clk_100M) begin
        if (alu_rise) begin
            result    <= alu_out;
            mem.addr  <= instr.m_form.imm;
            mem.wdata <= src_d;
        end
        if (reg_rise && op == OUT) begin
            out_data <= result;
        end
    end

    always_ff @(posedge clk_100M or negedge rst_n) begin
        if (!rst_n) begin
            alu_d  <= 1'b0;
            reg_d  <= 1'b0;
            mem.we <= 1'b0;
        end else begin
            alu_d <= ph.alu_ph;
            reg_d <= ph.reg_ph;
            if (alu_rise) begin
                mem.we <= (op == ST);
            end
        end
    end

    // Write-back, output strobe and halt
    always_ff @(posedge clk_100M or negedge rst_n) begin
        if (!rst_n) begin
            regs      <= '{default: '0};
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (reg_rise) begin
                case (op)
                    ADD, SUB, AND, OR, XOR: regs[instr.r_form.rd] <= result;
                    LDI:                    regs[instr.m_form.rd] <= result;
                    LD:                     regs[instr.m_form.rd] <= mem.rdata;
                    OUT:                    out_valid <= 1'b1;
                    HALT:                   halted <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_isa_pkg::*; (
    input  logic               clk_100M,
    input  logic               rst_n,
    input  logic               run,
    input  logic               prog_we,
    input  logic [PROG_AW-1:0] prog_addr,
    input  logic [INSTR_W-1:0] prog_data,
    output logic               out_valid,
    output logic [DATA_W-1:0]  out_data,
    output logic               halted
);

    instr_t instr;

    phase_if ph_bus ();
    mem_if   mem_bus ();

    phase_gen u_phase_gen (
        .clk_100M (clk_100M),
        .rst_n    (rst_n),
        .run      (run),
        .halted   (halted),
        .ph       (ph_bus)
    );

    instr_fetch u_instr_fetch (
        .clk_100M  (clk_100M),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (instr_t'(prog_data)),
        .ph        (ph_bus),
        .instr     (instr)
    );

    data_ram u_data_ram (
        .clk_100M (clk_100M),
        .rst_n    (rst_n),
        .ph       (ph_bus),
        .mem      (mem_bus)
    );

    exec_unit u_exec_unit (
        .clk_100M  (clk_100M),
        .rst_n     (rst_n),
        .ph        (ph_bus),
        .instr     (instr),
        .mem       (mem_bus),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

endmodule

// ==== tb/tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top import cpu_isa_pkg::*, cpu_timing_pkg::*; ();

    localparam int ALU_INSTRS   = 13;
    localparam int MEM_INSTRS   = 17;
    localparam int HALT_INSTRS  = 6;
    localparam int PAUSE_INSTRS = 11;
    // Frames for the reset idle time, the watch after HALT, the pause and the program loads
    localparam int IDLE_FRAMES  = 12;
    localparam int TOTAL_INSTRS = ALU_INSTRS + MEM_INSTRS + HALT_INSTRS + PAUSE_INSTRS;
    localparam int WATCHDOG_NS  = (TOTAL_INSTRS + IDLE_FRAMES) * FRAME_LEN * 10 * 2;

    logic               clk_100M;
    logic               rst_n;
    logic               run;
    logic               prog_we;
    logic [PROG_AW-1:0] prog_addr;
    logic [INSTR_W-1:0] prog_data;
    logic               out_valid;
    logic [DATA_W-1:0]  out_data;
    logic               halted;

    instr_t            prog_q[$];
    logic [DATA_W-1:0] exp_q[$];
    int                error_count;

    cpu_top DUT (
        .clk_100M  (clk_100M),
        .rst_n     (rst_n),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    initial begin
        clk_100M = 1'b0;
        forever #5 clk_100M = ~clk_100M;
    end

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_data(input string name, input logic [DATA_W-1:0] got,
                                input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic instr_t encode_alu(opcode_e op, int rd, int rs1, int rs2);
        instr_t w;
        w = '0;
        w.r_form.op  = op;
        w.r_form.rd  = REG_AW'(rd);
        w.r_form.rs1 = REG_AW'(rs1);
        w.r_form.rs2 = REG_AW'(rs2);
        return w;
    endfunction

    function automatic instr_t encode_imm(opcode_e op, int rd, logic [DATA_W-1:0] imm);
        instr_t w;
        w = '0;
        w.m_form.op  = op;
        w.m_form.rd  = REG_AW'(rd);
        w.m_form.imm = imm;
        return w;
    endfunction

    // Software model of the ISA that stops at the first HALT like the core does
    task automatic build_expected();
        logic [DATA_W-1:0] mregs [NREGS];
        logic [DATA_W-1:0] mmem [DATA_DEPTH];
        instr_t            ins;
        bit                stop;
        foreach (mregs[i]) mregs[i] = '0;
        foreach (mmem[i]) mmem[i] = '0;
        stop = 1'b0;
        for (int pc = 0; pc < prog_q.size() && !stop; pc++) begin
            ins = prog_q[pc];
            case (ins.r_form.op)
                ADD:  mregs[ins.r_form.rd] = mregs[ins.r_form.rs1] + mregs[ins.r_form.rs2];
                SUB:  mregs[ins.r_form.rd] = mregs[ins.r_form.rs1] - mregs[ins.r_form.rs2];
                AND:  mregs[ins.r_form.rd] = mregs[ins.r_form.rs1] & mregs[ins.r_form.rs2];
                OR:   mregs[ins.r_form.rd] = mregs[ins.r_form.rs1] | mregs[ins.r_form.rs2];
                XOR:  mregs[ins.r_form.rd] = mregs[ins.r_form.rs1] ^ mregs[ins.r_form.rs2];
                LDI:  mregs[ins.m_form.rd] = ins.m_form.imm;
                LD:   mregs[ins.m_form.rd] = mmem[ins.m_form.imm];
                ST:   mmem[ins.m_form.imm] = mregs[ins.m_form.rd];
                OUT:  exp_q.push_back(mregs[ins.m_form.rd]);
                HALT: stop = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic reset_dut();
        @(posedge clk_100M);
        #1;
        run     = 1'b0;
        prog_we = 1'b0;
        rst_n   = 1'b0;
        repeat (2) @(posedge clk_100M);
        #1;
        rst_n = 1'b1;
        prog_q.delete();
        exp_q.delete();
    endtask

    task automatic load_and_run();
        @(posedge clk_100M);
        #1;
        foreach (prog_q[i]) begin
            prog_we   = 1'b1;
            prog_addr = PROG_AW'(i);
            prog_data = prog_q[i];
            @(posedge clk_100M);
            #1;
        end
        prog_we = 1'b0;
        build_expected();
        run = 1'b1;
    endtask

    task automatic wait_for_halt();
        int limit;
        int n;
        limit = prog_q.size() * FRAME_LEN * 2 + 1000;
        n = 0;
        while (halted !== 1'b1) begin
            if (n >= limit) begin
                report_failure("halted did not rise within the expected number of frames");
            end
            @(negedge clk_100M);
            n++;
        end
    endtask

    task automatic check_all_out_seen();
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected OUT values never appeared", exp_q.size()));
        end
    endtask

    // Every OUT strobe must match the next value from the model
    always @(negedge clk_100M) begin
        if (rst_n === 1'b1 && out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_failure("out_valid pulsed when no further OUT value was expected");
            end else begin
                compare_data("out_data", out_data, exp_q.pop_front());
            end
        end
    end

    task automatic test_reset_state();
        reset_dut();
        @(negedge clk_100M);
        compare_flag("out_valid", out_valid, 1'b0);
        compare_flag("halted", halted, 1'b0);
        repeat (300) begin
            @(negedge clk_100M);
            compare_flag("out_valid", out_valid, 1'b0);
            compare_flag("halted", halted, 1'b0);
        end
    endtask

    task automatic test_alu_ops();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        reset_dut();
        a = DATA_W'($urandom);
        b = DATA_W'($urandom);
        prog_q.push_back(encode_imm(LDI, 1, a));
        prog_q.push_back(encode_imm(LDI, 2, b));
        prog_q.push_back(encode_alu(ADD, 3, 1, 2));
        prog_q.push_back(encode_imm(OUT, 3, 8'h00));
        prog_q.push_back(encode_alu(SUB, 4, 1, 2));
        prog_q.push_back(encode_imm(OUT, 4, 8'h00));
        prog_q.push_back(encode_alu(AND, 5, 1, 2));
        prog_q.push_back(encode_imm(OUT, 5, 8'h00));
        prog_q.push_back(encode_alu(OR, 6, 1, 2));
        prog_q.push_back(encode_imm(OUT, 6, 8'h00));
        prog_q.push_back(encode_alu(XOR, 7, 1, 2));
        prog_q.push_back(encode_imm(OUT, 7, 8'h00));
        prog_q.push_back(encode_imm(HALT, 0, 8'h00));
        load_and_run();
        wait_for_halt();
        check_all_out_seen();
    endtask

    task automatic test_mem_round_trip();
        logic [DATA_W-1:0]  vals [4];
        logic [DATA_AW-1:0] addrs [4];
        logic [DATA_AW-1:0] base;
        reset_dut();
        base = DATA_AW'($urandom);
        // An odd stride keeps the four addresses distinct
        for (int i = 0; i < 4; i++) begin
            vals[i]  = DATA_W'($urandom);
            addrs[i] = base + DATA_AW'(i * 61);
            prog_q.push_back(encode_imm(LDI, 1, vals[i]));
            prog_q.push_back(encode_imm(ST, 1, addrs[i]));
        end
        for (int i = 0; i < 4; i++) begin
            prog_q.push_back(encode_imm(LD, 2 + i, addrs[i]));
            prog_q.push_back(encode_imm(OUT, 2 + i, 8'h00));
        end
        prog_q.push_back(encode_imm(HALT, 0, 8'h00));
        load_and_run();
        wait_for_halt();
        check_all_out_seen();
    endtask

    task automatic test_halt();
        logic [DATA_W-1:0] v;
        reset_dut();
        v = DATA_W'($urandom);
        prog_q.push_back(encode_imm(LDI, 1, v));
        prog_q.push_back(encode_imm(OUT, 1, 8'h00));
        prog_q.push_back(encode_imm(HALT, 0, 8'h00));
        prog_q.push_back(encode_imm(OUT, 1, 8'h00));
        prog_q.push_back(encode_imm(LDI, 2, ~v));
        prog_q.push_back(encode_imm(OUT, 2, 8'h00));
        load_and_run();
        wait_for_halt();
        check_all_out_seen();
        repeat (3 * FRAME_LEN) begin
            @(negedge clk_100M);
            compare_flag("halted", halted, 1'b1);
            compare_flag("out_valid", out_valid, 1'b0);
        end
    endtask

    task automatic test_pause_run();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        int                run_cycles;
        int                hold_cycles;
        reset_dut();
        a = DATA_W'($urandom);
        b = DATA_W'($urandom);
        prog_q.push_back(encode_imm(LDI, 1, a));
        prog_q.push_back(encode_imm(LDI, 2, b));
        for (int k = 0; k < 4; k++) begin
            prog_q.push_back(encode_alu(ADD, 1, 1, 2));
            prog_q.push_back(encode_imm(OUT, 1, 8'h00));
        end
        prog_q.push_back(encode_imm(HALT, 0, 8'h00));
        run_cycles  = 100 + int'($urandom % 300);
        // The hold is longer than the gap between two OUTs so a core that ignores run would strobe
        hold_cycles = 3 * FRAME_LEN + int'($urandom % 200);
        load_and_run();
        repeat (run_cycles) @(posedge clk_100M);
        #1;
        run = 1'b0;
        repeat (hold_cycles) begin
            @(negedge clk_100M);
            compare_flag("out_valid", out_valid, 1'b0);
        end
        @(posedge clk_100M);
        #1;
        run = 1'b1;
        wait_for_halt();
        check_all_out_seen();
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("Watchdog expired before all tests finished");
    end

    initial begin
        rst_n       = 1'b0;
        run         = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        error_count = 0;
        void'($urandom(46));

        test_reset_state();
        test_alu_ops();
        test_mem_round_trip();
        test_halt();
        test_pause_run();

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hw/cpu_timing_pkg.sv
hw/cpu_isa_pkg.sv
hw/cpu_ifs.sv
hw/phase_gen.sv
hw/instr_fetch.sv
hw/data_ram.sv
hw/exec_unit.sv
hw/cpu_top.sv
tb/tb_cpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_cpu_top -f sim.f -o tb_cpu_top \
    && ./obj_dir/tb_cpu_top > "$LOG" 2>&1

cat "$LOG" 2>/dev/null

grep -qx "Done: no errors" "$LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
